//--- Makefile
# Verilator build and run for the HCI queue block

RTL_SRCS = hci_pkg.sv hci_csr.sv hci_cmd_queue.sv hci_read_queue.sv hci_top.sv

.PHONY: all run lint clean

all: run

obj_dir/Vtb_hci: src.f hci_macros.svh $(RTL_SRCS) tb_hci.sv
	verilator --binary --timing -Wno-fatal --top-module tb_hci -f src.f

run: obj_dir/Vtb_hci
	./obj_dir/Vtb_hci | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall +incdir+. --top-module hci_top $(RTL_SRCS)

clean:
	rm -rf obj_dir sim.log

//--- hci_cmd_queue.sv
// HCI command queue
// Packs DWORD pairs into 64-bit commands popped by the controller
`timescale 1ns/1ps
`default_nettype none
`include "hci_macros.svh"

module hci_cmd_queue
  import hci_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   we_i,
  input  logic [`HCI_CSR_DW-1:0] wdata_i,
  output logic                   wack_o,
  input  logic [`HCI_THLD_W-1:0] thld_i,
  input  logic                   reg_rst_i,
  output logic                   rst_clear_o,
  output logic                   cmd_rvalid_o,
  input  logic                   cmd_rready_i,
  output logic [`HCI_CMD_DW-1:0] cmd_rdata_o,
  output queue_status_t          status_o
);

  localparam int unsigned Depth = `HCI_CMD_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = `HCI_DEPTH_W;
  localparam int unsigned ThldW = `HCI_THLD_W;

  logic [`HCI_CMD_DW-1:0] mem_q [Depth];
  logic [`HCI_CSR_DW-1:0] lo_q;
  logic                   half_q;  // Low DWORD held
  logic [PtrW-1:0]        wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]        count_q, free_slots;
  logic [ThldW-1:0]       thld_eff;
  queue_rst_e             rst_state_q, rst_state_d;
  logic                   busy, full, push, pop;

  assign busy = reg_rst_i || (rst_state_q != RST_IDLE);
  assign full = (count_q == CntW'(Depth));

  assign wack_o       = we_i && !full && !busy;
  assign push         = wack_o && half_q;  // Second DWORD completes the command
  assign cmd_rvalid_o = (count_q != '0) && !busy;
  assign pop          = cmd_rvalid_o && cmd_rready_i;
  assign cmd_rdata_o  = mem_q[rd_ptr_q];

  always_comb begin
    rst_state_d = rst_state_q;
    case (rst_state_q)
      RST_IDLE:  if (reg_rst_i) rst_state_d = RST_FLUSH;
      RST_FLUSH: rst_state_d = RST_DONE;
      default:   rst_state_d = RST_IDLE;
    endcase
  end

  assign rst_clear_o = (rst_state_q == RST_DONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_state_q <= RST_IDLE;
      half_q      <= 1'b0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
    end else begin
      rst_state_q <= rst_state_d;
      if (rst_state_q == RST_FLUSH) begin
        half_q   <= 1'b0;  // Drop a half-written command
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (wack_o) half_q <= !half_q;
        if (push) wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        if (pop) rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        count_q <= count_q + CntW'(push) - CntW'(pop);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wack_o && !half_q) lo_q <= wdata_i;
    if (push) mem_q[wr_ptr_q] <= {wdata_i, lo_q};
  end

  // Free-slot threshold where 0 behaves as 1
  assign free_slots = CntW'(Depth) - count_q;
  assign thld_eff   = (thld_i == '0) ? ThldW'(1) : thld_i;

  always_comb begin
    status_o.full      = full;
    status_o.empty     = (count_q == '0);
    status_o.depth     = count_q;
    status_o.thld_trig = ThldW'(free_slots) >= thld_eff;
  end

endmodule

`default_nettype wire

//--- hci_csr.sv
// HCI register block
// Decodes the bus, holds reset and threshold registers, routes port accesses
`timescale 1ns/1ps
`default_nettype none
`include "hci_macros.svh"

module hci_csr
  import hci_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  csr_req_t               csr_req_i,
  output csr_rsp_t               csr_rsp_o,
  output logic                   cmd_we_o,
  output logic [`HCI_CSR_DW-1:0] cmd_wdata_o,
  input  logic                   cmd_wack_i,
  output logic                   resp_req_o,
  input  logic                   resp_ack_i,
  input  logic [`HCI_CSR_DW-1:0] resp_data_i,
  output logic                   ibi_req_o,
  input  logic                   ibi_ack_i,
  input  logic [`HCI_CSR_DW-1:0] ibi_data_i,
  output logic [2:0]             queue_rst_o,  // {ibi, resp, cmd}
  input  logic [2:0]             rst_clear_i,
  output logic [`HCI_THLD_W-1:0] cmd_thld_o,
  output logic [`HCI_THLD_W-1:0] resp_thld_o,
  output logic [`HCI_THLD_W-1:0] ibi_thld_o
);

  csr_reg_e               reg_sel;
  logic                   rd_req, wr_req, wr_stall;
  logic                   rd_err_d, wr_err_d;
  logic [`HCI_CSR_DW-1:0] rd_data_d;
  logic [2:0]             rst_set;
  logic                   rd_ack_q, rd_err_q, wr_ack_q, wr_err_q;
  logic [`HCI_CSR_DW-1:0] rd_data_q;
  logic [2:0]             queue_rst_q;
  logic [`HCI_THLD_W-1:0] cmd_thld_q, resp_thld_q, ibi_thld_q;

  always_comb begin
    case (csr_req_i.addr)
      `HCI_OFS_RESET_CONTROL:   reg_sel = REG_RESET_CONTROL;
      `HCI_OFS_QUEUE_THLD_CTRL: reg_sel = REG_QUEUE_THLD_CTRL;
      `HCI_OFS_COMMAND_PORT:    reg_sel = REG_COMMAND_PORT;
      `HCI_OFS_RESPONSE_PORT:   reg_sel = REG_RESPONSE_PORT;
      `HCI_OFS_IBI_PORT:        reg_sel = REG_IBI_PORT;
      default:                  reg_sel = REG_NONE;
    endcase
  end

  assign rd_req = csr_req_i.req && !csr_req_i.req_is_wr;
  assign wr_req = csr_req_i.req && csr_req_i.req_is_wr;

  assign cmd_we_o    = wr_req && (reg_sel == REG_COMMAND_PORT);
  assign cmd_wdata_o = csr_req_i.wr_data;
  assign resp_req_o  = rd_req && (reg_sel == REG_RESPONSE_PORT);
  assign ibi_req_o   = rd_req && (reg_sel == REG_IBI_PORT);
  assign wr_stall    = cmd_we_o && !cmd_wack_i;  // Command queue full or flushing

  always_comb begin
    rd_data_d = '0;
    rd_err_d  = 1'b0;
    case (reg_sel)
      REG_RESET_CONTROL:   rd_data_d = {28'b0, queue_rst_q, 1'b0};
      REG_QUEUE_THLD_CTRL: rd_data_d = {8'b0, ibi_thld_q, resp_thld_q, cmd_thld_q};
      REG_RESPONSE_PORT: begin
        rd_data_d = resp_ack_i ? resp_data_i : '0;
        rd_err_d  = !resp_ack_i;
      end
      REG_IBI_PORT: begin
        rd_data_d = ibi_ack_i ? ibi_data_i : '0;
        rd_err_d  = !ibi_ack_i;
      end
      default:             rd_err_d = 1'b1;  // Command port is write only
    endcase
  end

  // Only the two control registers and the command port take writes
  assign wr_err_d = (reg_sel != REG_RESET_CONTROL) && (reg_sel != REG_QUEUE_THLD_CTRL) &&
                    (reg_sel != REG_COMMAND_PORT);
  assign rst_set  = (wr_req && reg_sel == REG_RESET_CONTROL) ? csr_req_i.wr_data[3:1] : 3'b0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q    <= 1'b0;
      rd_err_q    <= 1'b0;
      wr_ack_q    <= 1'b0;
      wr_err_q    <= 1'b0;
      queue_rst_q <= '0;
      cmd_thld_q  <= `HCI_THLD_W'(1);
      resp_thld_q <= `HCI_THLD_W'(1);
      ibi_thld_q  <= `HCI_THLD_W'(1);
    end else begin
      rd_ack_q    <= rd_req;
      rd_err_q    <= rd_req && rd_err_d;
      wr_ack_q    <= wr_req && !wr_stall;
      wr_err_q    <= wr_req && wr_err_d;
      queue_rst_q <= (queue_rst_q & ~rst_clear_i) | rst_set;  // A new write wins
      if (wr_req && reg_sel == REG_QUEUE_THLD_CTRL) begin
        cmd_thld_q  <= csr_req_i.wr_data[7:0];
        resp_thld_q <= csr_req_i.wr_data[15:8];
        ibi_thld_q  <= csr_req_i.wr_data[23:16];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_q <= rd_req ? rd_data_d : '0;
  end

  always_comb begin
    csr_rsp_o.rd_ack   = rd_ack_q;
    csr_rsp_o.rd_err   = rd_err_q;
    csr_rsp_o.rd_data  = rd_data_q;
    csr_rsp_o.wr_ack   = wr_ack_q;
    csr_rsp_o.wr_err   = wr_err_q;
    csr_rsp_o.wr_stall = wr_stall;
  end

  assign queue_rst_o = queue_rst_q;
  assign cmd_thld_o  = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;
  assign ibi_thld_o  = ibi_thld_q;

endmodule

`default_nettype wire

//--- hci_macros.svh
// HCI queue block parameters
// Queue depths, field widths and register offsets
`ifndef HCI_MACROS_SVH
`define HCI_MACROS_SVH

`define HCI_CSR_AW     8
`define HCI_CSR_DW     32
`define HCI_CMD_DW     64

`define HCI_CMD_DEPTH  8
`define HCI_RESP_DEPTH 16
`define HCI_IBI_DEPTH  16
`define HCI_DEPTH_W    5   // Holds a count of 0..16
`define HCI_THLD_W     8

`define HCI_OFS_RESET_CONTROL   8'h00
`define HCI_OFS_QUEUE_THLD_CTRL 8'h04
`define HCI_OFS_COMMAND_PORT    8'h08
`define HCI_OFS_RESPONSE_PORT   8'h0C
`define HCI_OFS_IBI_PORT        8'h10

`endif

//--- hci_pkg.sv
// HCI queue block types
// Register bus structs, queue status and the decoded register select
`default_nettype none
`include "hci_macros.svh"

package hci_pkg;

  typedef struct packed {
    logic                   req;
    logic                   req_is_wr;
    logic [`HCI_CSR_AW-1:0] addr;
    logic [`HCI_CSR_DW-1:0] wr_data;
  } csr_req_t;

  typedef struct packed {
    logic                   rd_ack;
    logic                   rd_err;
    logic [`HCI_CSR_DW-1:0] rd_data;
    logic                   wr_ack;
    logic                   wr_err;
    logic                   wr_stall;  // Request must be held while high
  } csr_rsp_t;

  typedef struct packed {
    logic                    full;
    logic                    empty;
    logic [`HCI_DEPTH_W-1:0] depth;
    logic                    thld_trig;
  } queue_status_t;

  typedef enum logic [2:0] {
    REG_RESET_CONTROL   = 3'd0,
    REG_QUEUE_THLD_CTRL = 3'd1,
    REG_COMMAND_PORT    = 3'd2,
    REG_RESPONSE_PORT   = 3'd3,
    REG_IBI_PORT        = 3'd4,
    REG_NONE            = 3'd5
  } csr_reg_e;

  typedef enum logic [1:0] {RST_IDLE, RST_FLUSH, RST_DONE} queue_rst_e;

endpackage

`default_nettype wire

//--- hci_read_queue.sv
// HCI read queue
// Controller-filled FIFO drained by register reads, for response and IBI
`timescale 1ns/1ps
`default_nettype none
`include "hci_macros.svh"

module hci_read_queue
  import hci_pkg::*;
#(
  parameter int unsigned Depth = `HCI_RESP_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  logic [`HCI_CSR_DW-1:0] wdata_i,
  input  logic                   req_i,
  output logic                   ack_o,
  output logic [`HCI_CSR_DW-1:0] data_o,
  input  logic [`HCI_THLD_W-1:0] thld_i,
  input  logic                   reg_rst_i,
  output logic                   rst_clear_o,
  output queue_status_t          status_o
);

  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = `HCI_DEPTH_W;
  localparam int unsigned ThldW = `HCI_THLD_W;

  logic [`HCI_CSR_DW-1:0] mem_q [Depth];
  logic [PtrW-1:0]        wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]        count_q;
  logic [ThldW-1:0]       thld_eff;
  queue_rst_e             rst_state_q, rst_state_d;
  logic                   busy, full, empty, push;

  assign busy  = reg_rst_i || (rst_state_q != RST_IDLE);
  assign full  = (count_q == CntW'(Depth));
  assign empty = (count_q == '0);

  assign wready_o = !full && !busy;
  assign push     = wvalid_i && wready_o;
  assign ack_o    = req_i && !empty && !busy;  // Ack means the head was popped
  assign data_o   = mem_q[rd_ptr_q];

  always_comb begin
    rst_state_d = rst_state_q;
    case (rst_state_q)
      RST_IDLE:  if (reg_rst_i) rst_state_d = RST_FLUSH;
      RST_FLUSH: rst_state_d = RST_DONE;
      default:   rst_state_d = RST_IDLE;
    endcase
  end

  assign rst_clear_o = (rst_state_q == RST_DONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_state_q <= RST_IDLE;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
    end else begin
      rst_state_q <= rst_state_d;
      if (rst_state_q == RST_FLUSH) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        if (ack_o) rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        count_q <= count_q + CntW'(push) - CntW'(ack_o);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  assign thld_eff = (thld_i == '0) ? ThldW'(1) : thld_i;  // 0 acts as 1

  always_comb begin
    status_o.full      = full;
    status_o.empty     = empty;
    status_o.depth     = count_q;
    status_o.thld_trig = ThldW'(count_q) >= thld_eff;
  end

endmodule

`default_nettype wire

//--- hci_top.sv
// HCI queue block top level
// Register block in front of the command, response and IBI queues
`timescale 1ns/1ps
`default_nettype none
`include "hci_macros.svh"

module hci_top
  import hci_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  csr_req_t               csr_req_i,
  output csr_rsp_t               csr_rsp_o,
  output logic                   cmd_rvalid_o,
  input  logic                   cmd_rready_i,
  output logic [`HCI_CMD_DW-1:0] cmd_rdata_o,
  input  logic                   resp_wvalid_i,
  output logic                   resp_wready_o,
  input  logic [`HCI_CSR_DW-1:0] resp_wdata_i,
  input  logic                   ibi_wvalid_i,
  output logic                   ibi_wready_o,
  input  logic [`HCI_CSR_DW-1:0] ibi_wdata_i,
  output queue_status_t          cmd_status_o,
  output queue_status_t          resp_status_o,
  output queue_status_t          ibi_status_o
);

  logic                   cmd_we, cmd_wack, resp_req, resp_ack, ibi_req, ibi_ack;
  logic [`HCI_CSR_DW-1:0] cmd_wdata, resp_data, ibi_data;
  logic [`HCI_THLD_W-1:0] cmd_thld, resp_thld, ibi_thld;
  logic [2:0]             queue_rst, rst_clear;  // {ibi, resp, cmd}

  hci_csr u_csr (
    .clk_i, .rst_ni, .csr_req_i, .csr_rsp_o,
    .cmd_we_o(cmd_we), .cmd_wdata_o(cmd_wdata), .cmd_wack_i(cmd_wack),
    .resp_req_o(resp_req), .resp_ack_i(resp_ack), .resp_data_i(resp_data),
    .ibi_req_o(ibi_req), .ibi_ack_i(ibi_ack), .ibi_data_i(ibi_data),
    .queue_rst_o(queue_rst), .rst_clear_i(rst_clear),
    .cmd_thld_o(cmd_thld), .resp_thld_o(resp_thld), .ibi_thld_o(ibi_thld)
  );

  hci_cmd_queue u_cmd_queue (
    .clk_i, .rst_ni,
    .we_i(cmd_we), .wdata_i(cmd_wdata), .wack_o(cmd_wack), .thld_i(cmd_thld),
    .reg_rst_i(queue_rst[0]), .rst_clear_o(rst_clear[0]),
    .cmd_rvalid_o, .cmd_rready_i, .cmd_rdata_o, .status_o(cmd_status_o)
  );

  hci_read_queue #(.Depth(`HCI_RESP_DEPTH)) u_resp_queue (
    .clk_i, .rst_ni,
    .wvalid_i(resp_wvalid_i), .wready_o(resp_wready_o), .wdata_i(resp_wdata_i),
    .req_i(resp_req), .ack_o(resp_ack), .data_o(resp_data), .thld_i(resp_thld),
    .reg_rst_i(queue_rst[1]), .rst_clear_o(rst_clear[1]), .status_o(resp_status_o)
  );

  hci_read_queue #(.Depth(`HCI_IBI_DEPTH)) u_ibi_queue (
    .clk_i, .rst_ni,
    .wvalid_i(ibi_wvalid_i), .wready_o(ibi_wready_o), .wdata_i(ibi_wdata_i),
    .req_i(ibi_req), .ack_o(ibi_ack), .data_o(ibi_data), .thld_i(ibi_thld),
    .reg_rst_i(queue_rst[2]), .rst_clear_o(rst_clear[2]), .status_o(ibi_status_o)
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+.
hci_pkg.sv
hci_csr.sv
hci_cmd_queue.sv
hci_read_queue.sv
hci_top.sv
tb_hci.sv

//--- tb_hci.sv
// Testbench for the HCI queue block
// Random bus and controller traffic checked against queue models
`timescale 1ns/1ps
`default_nettype none
`include "hci_macros.svh"

module tb_hci
  import hci_pkg::*;
();

  localparam int ClkPeriod  = 40;
  localparam int NumCmd     = 48;  // Command pairs
  localparam int NumRead    = 120;
  localparam int NumThld    = 16;
  localparam int NumRst     = 8;
  localparam int NumErr     = 24;
  localparam int StallLimit = 64;
  localparam int WatchdogCycles =
    (2 * NumCmd + NumRead + 6 * NumThld + 20 * NumRst + NumErr) * 10 + 1000;

  logic                   clk, rst_n;
  csr_req_t               csr_req;
  csr_rsp_t               csr_rsp;
  logic                   cmd_rvalid, cmd_rready;
  logic [`HCI_CMD_DW-1:0] cmd_rdata;
  logic                   resp_wvalid, resp_wready, ibi_wvalid, ibi_wready;
  logic [`HCI_CSR_DW-1:0] resp_wdata, ibi_wdata;
  queue_status_t          cmd_status, resp_status, ibi_status;

  logic [`HCI_CMD_DW-1:0] cmd_model[$];
  logic [`HCI_CSR_DW-1:0] resp_model[$];
  logic [`HCI_CSR_DW-1:0] ibi_model[$];
  logic                   half_v;  // Low DWORD held in the model
  logic [`HCI_CSR_DW-1:0] half_lo;
  logic [`HCI_THLD_W-1:0] thld_m [3];
  int                     rst_cnt [3];  // Cycles left in a queue reset
  logic                   pend_rd, pend_wr, exp_rd_err, exp_wr_err;
  logic [`HCI_CSR_DW-1:0] exp_rd_data;
  int                     pop_rate, push_rate;  // Out of 8 per cycle
  int                     checks, mismatches, failures;
  string                  cur_test;
  logic [31:0]            rng_bus, rng_ctl;

  hci_top UUT (
    .clk_i(clk), .rst_ni(rst_n), .csr_req_i(csr_req), .csr_rsp_o(csr_rsp),
    .cmd_rvalid_o(cmd_rvalid), .cmd_rready_i(cmd_rready), .cmd_rdata_o(cmd_rdata),
    .resp_wvalid_i(resp_wvalid), .resp_wready_o(resp_wready), .resp_wdata_i(resp_wdata),
    .ibi_wvalid_i(ibi_wvalid), .ibi_wready_o(ibi_wready), .ibi_wdata_i(ibi_wdata),
    .cmd_status_o(cmd_status), .resp_status_o(resp_status), .ibi_status_o(ibi_status)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_bus_rand();
    rng_bus = xorshift(rng_bus);
    return rng_bus;
  endfunction

  // {full, empty, depth, thld_trig} from a model count
  function automatic logic [7:0] expect_status(input int n, input int depth, input logic by_free,
                                               input logic [7:0] thld);
    int   eff;
    logic trig;
    eff  = (thld == 0) ? 1 : int'(thld);
    trig = by_free ? ((depth - n) >= eff) : (n >= eff);
    return {n == depth, n == 0, n[4:0], trig};
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  // Checks this cycle, then applies the handshakes of the coming edge to the models
  task automatic observe_cycle();
    int         cn, rn, inn, q;
    logic [2:0] busy, rst_new;
    logic       exp_stall;
    cn      = cmd_model.size();
    rn      = resp_model.size();
    inn     = ibi_model.size();
    busy    = {rst_cnt[2] != 0, rst_cnt[1] != 0, rst_cnt[0] != 0};
    rst_new = 3'b0;
    if (pend_rd) begin
      check_value("rd_ack", 1, csr_rsp.rd_ack);
      check_value("rd_err", exp_rd_err, csr_rsp.rd_err);
      check_value("rd_data", exp_rd_data, csr_rsp.rd_data);
    end else if (csr_rsp.rd_ack) begin
      report_failure("read ack without a pending read");
    end
    if (pend_wr) begin
      check_value("wr_ack", 1, csr_rsp.wr_ack);
      check_value("wr_err", exp_wr_err, csr_rsp.wr_err);
    end else if (csr_rsp.wr_ack) begin
      report_failure("write ack without an accepted write");
    end
    pend_rd = 1'b0;
    pend_wr = 1'b0;
    check_value("cmd_status", expect_status(cn, `HCI_CMD_DEPTH, 1'b1, thld_m[0]), cmd_status);
    check_value("resp_status", expect_status(rn, `HCI_RESP_DEPTH, 1'b0, thld_m[1]), resp_status);
    check_value("ibi_status", expect_status(inn, `HCI_IBI_DEPTH, 1'b0, thld_m[2]), ibi_status);
    check_value("cmd_rvalid", (cn != 0) && !busy[0], cmd_rvalid);
    check_value("resp_wready", (rn < `HCI_RESP_DEPTH) && !busy[1], resp_wready);
    check_value("ibi_wready", (inn < `HCI_IBI_DEPTH) && !busy[2], ibi_wready);

    if (cn != 0 && !busy[0] && cmd_rready) begin
      check_value("cmd_rdata", cmd_model[0], cmd_rdata);
      cmd_model.delete(0);
    end

    exp_stall = 1'b0;
    if (csr_req.req && csr_req.req_is_wr) begin
      if (csr_req.addr == `HCI_OFS_COMMAND_PORT) exp_stall = (cn == `HCI_CMD_DEPTH) || busy[0];
      if (!exp_stall) begin
        pend_wr    = 1'b1;
        exp_wr_err = !(csr_req.addr inside {`HCI_OFS_RESET_CONTROL, `HCI_OFS_QUEUE_THLD_CTRL,
                                            `HCI_OFS_COMMAND_PORT});
        case (csr_req.addr)
          `HCI_OFS_RESET_CONTROL:   rst_new = csr_req.wr_data[3:1];
          `HCI_OFS_QUEUE_THLD_CTRL: begin
            thld_m[0] = csr_req.wr_data[7:0];
            thld_m[1] = csr_req.wr_data[15:8];
            thld_m[2] = csr_req.wr_data[23:16];
          end
          `HCI_OFS_COMMAND_PORT: begin
            if (half_v) cmd_model.push_back({csr_req.wr_data, half_lo});
            else half_lo = csr_req.wr_data;
            half_v = !half_v;
          end
          default: ;
        endcase
      end
    end else if (csr_req.req) begin
      pend_rd     = 1'b1;
      exp_rd_err  = 1'b0;
      exp_rd_data = '0;
      case (csr_req.addr)
        `HCI_OFS_RESET_CONTROL:   exp_rd_data = {28'b0, busy, 1'b0};
        `HCI_OFS_QUEUE_THLD_CTRL: exp_rd_data = {8'b0, thld_m[2], thld_m[1], thld_m[0]};
        `HCI_OFS_RESPONSE_PORT: begin
          if (rn != 0 && !busy[1]) exp_rd_data = resp_model[0];
          if (rn != 0 && !busy[1]) resp_model.delete(0);
          else exp_rd_err = 1'b1;
        end
        `HCI_OFS_IBI_PORT: begin
          if (inn != 0 && !busy[2]) exp_rd_data = ibi_model[0];
          if (inn != 0 && !busy[2]) ibi_model.delete(0);
          else exp_rd_err = 1'b1;
        end
        default: exp_rd_err = 1'b1;
      endcase
    end
    check_value("wr_stall", exp_stall, csr_rsp.wr_stall);

    if (resp_wvalid && rn < `HCI_RESP_DEPTH && !busy[1]) resp_model.push_back(resp_wdata);
    if (ibi_wvalid && inn < `HCI_IBI_DEPTH && !busy[2]) ibi_model.push_back(ibi_wdata);

    // Flush lands on the second edge of the reset sequence
    for (q = 0; q < 3; q++) begin
      if (rst_cnt[q] == 2 && q == 0) begin
        cmd_model.delete();
        half_v = 1'b0;
      end
      if (rst_cnt[q] == 2 && q == 1) resp_model.delete();
      if (rst_cnt[q] == 2 && q == 2) ibi_model.delete();
      if (rst_cnt[q] != 0) rst_cnt[q]--;
      if (rst_new[q]) rst_cnt[q] = 3;
    end
  endtask

  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int   waited;
    logic stuck;
    rdata = '0;
    @(posedge clk);
    csr_req <= '{req: 1'b1, req_is_wr: wr, addr: addr, wr_data: wdata};
    @(negedge clk);
    waited = 0;
    while (csr_rsp.wr_stall && waited < StallLimit) begin
      @(negedge clk);
      waited++;
    end
    stuck = csr_rsp.wr_stall;
    @(posedge clk);
    csr_req <= '0;
    if (stuck) begin
      report_failure($sformatf("write to 0x%02h still stalled after %0d cycles", addr, waited));
    end else begin
      @(negedge clk);
      waited = 0;
      while (!(csr_rsp.rd_ack || csr_rsp.wr_ack) && waited < 4) begin
        @(negedge clk);
        waited++;
      end
      if (csr_rsp.rd_ack || csr_rsp.wr_ack) rdata = csr_rsp.rd_data;
      else report_failure($sformatf("no ack for access to 0x%02h", addr));
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  task automatic set_traffic(input int pops, input int pushes);
    @(negedge clk);
    pop_rate  = pops;
    push_rate = pushes;
  endtask

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Controller side traffic
  always @(posedge clk) begin
    rng_ctl = xorshift(rng_ctl);
    cmd_rready  <= (int'(rng_ctl[2:0]) < pop_rate);
    resp_wvalid <= (int'(rng_ctl[5:3]) < push_rate);
    ibi_wvalid  <= (int'(rng_ctl[8:6]) < push_rate);
    rng_ctl = xorshift(rng_ctl);
    resp_wdata <= rng_ctl;
    rng_ctl = xorshift(rng_ctl);
    ibi_wdata <= rng_ctl;
  end

  always @(negedge clk) begin
    if (rst_n) observe_cycle();
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WatchdogCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r, d;
    logic [7:0]  a;
    logic [2:0]  mask;
    int          i, k;
    rst_n = 1'b0;
    csr_req = '0;
    cmd_rready = 1'b0;
    resp_wvalid = 1'b0;
    ibi_wvalid = 1'b0;
    resp_wdata = '0;
    ibi_wdata = '0;
    rng_bus = 32'd99;
    rng_ctl = 32'd99;
    half_v = 1'b0;
    half_lo = '0;
    thld_m = '{default: 8'd1};
    rst_cnt = '{default: 0};
    pend_rd = 1'b0;
    pend_wr = 1'b0;
    exp_rd_err = 1'b0;
    exp_wr_err = 1'b0;
    exp_rd_data = '0;
    pop_rate = 0;
    push_rate = 0;
    checks = 0;
    mismatches = 0;
    failures = 0;
    cur_test = "reset";
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "cmd_path";
    set_traffic(1, 0);  // Slow pops so the queue fills
    for (i = 0; i < NumCmd; i++) begin
      if (i == NumCmd / 2) set_traffic(5, 0);
      bus_write(`HCI_OFS_COMMAND_PORT, next_bus_rand());
      bus_write(`HCI_OFS_COMMAND_PORT, next_bus_rand());
    end
    set_traffic(8, 0);
    repeat (12) @(posedge clk);

    cur_test = "read_path";
    set_traffic(0, 5);
    for (i = 0; i < NumRead; i++) begin
      if (i == NumRead / 2) set_traffic(0, 1);  // Drain until empty
      r = next_bus_rand();
      bus_read(r[0] ? `HCI_OFS_RESPONSE_PORT : `HCI_OFS_IBI_PORT, d);
    end

    cur_test = "thresholds";
    set_traffic(3, 3);
    for (i = 0; i < NumThld; i++) begin
      r = next_bus_rand();
      d = {8'b0, 3'b0, r[20:16], 3'b0, r[12:8], 3'b0, r[4:0]};
      if (i % 4 == 0) d[7:0] = 8'd0;
      if (i % 4 == 1) d[15:8] = 8'd0;
      if (i % 4 == 2) d[23:16] = 8'd0;
      bus_write(`HCI_OFS_QUEUE_THLD_CTRL, d);
      bus_write(`HCI_OFS_COMMAND_PORT, next_bus_rand());
      for (k = 0; k < 4; k++) begin
        r = next_bus_rand();
        bus_read(r[1] ? `HCI_OFS_RESPONSE_PORT : `HCI_OFS_IBI_PORT, d);
      end
    end

    cur_test = "queue_reset";
    for (i = 0; i < NumRst; i++) begin
      set_traffic(2, 6);
      r = next_bus_rand();
      for (k = 0; k <= int'(r[1:0]); k++) bus_write(`HCI_OFS_COMMAND_PORT, next_bus_rand());
      repeat (4) @(posedge clk);
      set_traffic(0, 0);
      mask = r[6:4];
      if (mask == 3'b0) mask = 3'b111;
      bus_write(`HCI_OFS_RESET_CONTROL, {28'b0, mask, 1'b0});
      repeat (2) @(posedge clk);
      bus_read(`HCI_OFS_RESET_CONTROL, d);
      check_value("reset_bits", 0, d[3:1]);
      if (mask[0]) check_value("cmd_empty", 1, cmd_status.empty);
      if (mask[1]) check_value("resp_empty", 1, resp_status.empty);
      if (mask[2]) check_value("ibi_empty", 1, ibi_status.empty);
    end
    set_traffic(8, 0);
    bus_write(`HCI_OFS_COMMAND_PORT, next_bus_rand());
    bus_write(`HCI_OFS_COMMAND_PORT, next_bus_rand());
    repeat (12) @(posedge clk);

    cur_test = "bus_errors";
    set_traffic(3, 3);
    for (i = 0; i < NumErr; i++) begin
      r = next_bus_rand();
      a = r[7:0];
      if (a <= 8'h10 && a[1:0] == 2'b0) a = a | 8'h80;  // Off the register map
      case (i % 4)
        0:       bus_read(a, d);
        1:       bus_write(a, r);
        2:       bus_read(`HCI_OFS_COMMAND_PORT, d);
        default: bus_write(`HCI_OFS_RESPONSE_PORT, r);
      endcase
    end
    set_traffic(0, 0);
    repeat (4) @(posedge clk);
    @(negedge clk);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
